/* pingpong_fifo.f */
src/pingpong_pkg.sv
src/bank_handoff_if.sv
src/bank_memory.sv
src/write_bank_control.sv
src/read_bank_arbiter.sv
src/pingpong_fifo.sv
verif/pingpong_fifo_assertions.sv
verif/pingpong_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ping-pong FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f pingpong_fifo.f \
  --top-module pingpong_fifo_tb

./obj_dir/Vpingpong_fifo_tb 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi
echo "Simulation passed"

/* src/bank_handoff_if.sv */
// Bank hand-over between write side and read side
// Commit passes a filled bank to the reader, release returns it
`timescale 1ns/1ps
`default_nettype none

interface bank_handoff_if;

  import pingpong_pkg::*;

  // Writer to reader, one-cycle pulse with bank and its word count
  logic   commit;
  bank_t  commit_bank;
  count_t commit_count;

  // Reader to writer, one-cycle pulse once the bank is read out
  logic   release_event;
  bank_t  release_bank;

  modport writer (
    output commit,
    output commit_bank,
    output commit_count,
    input  release_event,
    input  release_bank
  );

  modport reader (
    input  commit,
    input  commit_bank,
    input  commit_count,
    output release_event,
    output release_bank
  );

endinterface

`default_nettype wire

/* src/bank_memory.sv */
// Two-bank word storage
// One write port, one registered read port, banks split by the top address bit
`timescale 1ns/1ps
`default_nettype none

module bank_memory (
  input  wire logic                  write_clock,
  input  wire logic                  mem_write_enable,
  input  wire pingpong_pkg::ram_addr_t mem_write_address,
  input  wire pingpong_pkg::data_t   mem_write_data,
  input  wire pingpong_pkg::ram_addr_t mem_read_address,
  output pingpong_pkg::data_t        mem_read_data
);

  import pingpong_pkg::*;

  // Both banks in one array
  data_t storage [NUM_BANKS * BANK_DEPTH];

  // Write port
  always_ff @(posedge write_clock) begin
    if (mem_write_enable) begin
      storage[mem_write_address] <= mem_write_data;
    end
  end

  // Read port, data one cycle after the address
  // Same-cycle write to the read address returns the old word
  always_ff @(posedge write_clock) begin
    mem_read_data <= storage[mem_read_address];
  end

endmodule

`default_nettype wire

/* src/pingpong_fifo.sv */
// Ping-pong FIFO top level
// Two banks, filled by bursts on the write side and read out whole,
// oldest first, on the read side
`timescale 1ns/1ps
`default_nettype none

module pingpong_fifo (
  input  wire logic                     write_clock,
  input  wire logic                     reset,

  // Write side
  output pingpong_pkg::bank_mask_t      write_ready,
  input  wire pingpong_pkg::bank_mask_t write_activate,
  input  wire logic                     write_strobe,
  input  wire pingpong_pkg::data_t      write_data,

  // Read side
  output logic                          read_ready,
  input  wire logic                     read_activate,
  input  wire logic                     read_strobe,
  output pingpong_pkg::count_t          read_count,
  output pingpong_pkg::data_t           read_data
);

  import pingpong_pkg::*;

  // Memory ports
  logic      mem_write_enable;
  ram_addr_t mem_write_address;
  data_t     mem_write_data;
  ram_addr_t mem_read_address;
  data_t     mem_read_data;

  // Commit and release events between the two sides
  bank_handoff_if handoff ();

  write_bank_control i_write_bank_control (
    .write_clock       (write_clock),
    .reset             (reset),
    .write_ready       (write_ready),
    .write_activate    (write_activate),
    .write_strobe      (write_strobe),
    .write_data        (write_data),
    .handoff           (handoff.writer),
    .mem_write_enable  (mem_write_enable),
    .mem_write_address (mem_write_address),
    .mem_write_data    (mem_write_data)
  );

  read_bank_arbiter i_read_bank_arbiter (
    .write_clock      (write_clock),
    .reset            (reset),
    .read_ready       (read_ready),
    .read_activate    (read_activate),
    .read_strobe      (read_strobe),
    .read_count       (read_count),
    .read_data        (read_data),
    .handoff          (handoff.reader),
    .mem_read_address (mem_read_address),
    .mem_read_data    (mem_read_data)
  );

  bank_memory i_bank_memory (
    .write_clock       (write_clock),
    .mem_write_enable  (mem_write_enable),
    .mem_write_address (mem_write_address),
    .mem_write_data    (mem_write_data),
    .mem_read_address  (mem_read_address),
    .mem_read_data     (mem_read_data)
  );

endmodule

`default_nettype wire

/* src/pingpong_pkg.sv */
// Ping-pong FIFO shared definitions
// Sizes of the two banks and the word, bank and address types
`default_nettype none

package pingpong_pkg;

  // Word and bank geometry
  localparam int DATA_WIDTH    = 8;
  localparam int ADDRESS_WIDTH = 4;
  localparam int BANK_DEPTH    = 1 << ADDRESS_WIDTH;
  localparam int NUM_BANKS     = 2;
  localparam int BANK_WIDTH    = $clog2(NUM_BANKS);

  // One data word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Word offset inside one bank
  typedef logic [ADDRESS_WIDTH-1:0] offset_t;

  // Words held by a bank, 0 up to BANK_DEPTH inclusive
  typedef logic [ADDRESS_WIDTH:0] count_t;

  // Bank index
  typedef logic [BANK_WIDTH-1:0] bank_t;

  // One bit per bank, used for write_ready and write_activate
  typedef logic [NUM_BANKS-1:0] bank_mask_t;

  // Memory address, bank index above the offset
  typedef logic [BANK_WIDTH+ADDRESS_WIDTH-1:0] ram_addr_t;

endpackage

`default_nettype wire

/* src/read_bank_arbiter.sv */
// Read side of the ping-pong FIFO
// Tracks committed banks, offers the oldest one with its count,
// steps through it on read strobes and releases it back to the writer
`timescale 1ns/1ps
`default_nettype none

module read_bank_arbiter (
  input  wire logic                     write_clock,
  input  wire logic                     reset,
  output logic                          read_ready,
  input  wire logic                     read_activate,
  input  wire logic                     read_strobe,
  output pingpong_pkg::count_t          read_count,
  output pingpong_pkg::data_t           read_data,
  bank_handoff_if.reader                handoff,
  output pingpong_pkg::ram_addr_t       mem_read_address,
  input  wire pingpong_pkg::data_t      mem_read_data
);

  import pingpong_pkg::*;

  typedef enum logic [1:0] {
    PHASE_IDLE,
    PHASE_OFFERED,
    PHASE_READING
  } phase_t;

  phase_t     phase;

  // Banks committed and not yet offered
  bank_mask_t full;
  bank_mask_t full_next;
  bank_mask_t commit_mask;
  count_t     bank_count [NUM_BANKS];

  // Earliest committed bank among the full ones
  bank_t      oldest;

  bank_t      take_bank;
  bank_t      sel_bank;
  offset_t    offset;
  offset_t    offset_next;
  logic       offer_now;
  logic       step;

  always_comb begin
    commit_mask = '0;
    if (handoff.commit) begin
      commit_mask[handoff.commit_bank] = 1'b1;
    end

    // Offer as soon as idle and something is waiting, a fresh commit included
    offer_now = (phase == PHASE_IDLE) && ((full != '0) || handoff.commit);
    // A waiting bank is always older than one committed this cycle
    take_bank = (full != '0) ? oldest : handoff.commit_bank;

    full_next = full | commit_mask;
    if (offer_now) begin
      full_next[take_bank] = 1'b0;
    end
  end

  // Advance only while the user holds the bank
  assign step        = (phase != PHASE_IDLE) && read_activate && read_strobe;
  assign offset_next = step ? offset + 1'b1 : offset;

  // Word 0 of the next bank is addressed while idle
  // so it is on read_data when read_ready rises
  assign mem_read_address = (phase == PHASE_IDLE) ? {take_bank, offset_t'(0)} :
                                                    {sel_bank, offset_next};
  assign read_data  = mem_read_data;
  assign read_ready = (phase == PHASE_OFFERED);

  // Phase, full mask, age order and release pulse
  always_ff @(posedge write_clock) begin
    if (reset) begin
      phase                 <= PHASE_IDLE;
      full                  <= '0;
      oldest                <= '0;
      handoff.release_event <= 1'b0;
    end else begin
      handoff.release_event <= 1'b0;
      full                  <= full_next;

      // With both banks full keep the order, otherwise follow the single one
      if (full_next != '1) begin
        oldest <= bank_t'(full_next[1]);
      end

      case (phase)
        PHASE_IDLE: begin
          if (offer_now) begin
            phase <= PHASE_OFFERED;
          end
        end
        PHASE_OFFERED: begin
          if (read_activate) begin
            phase <= PHASE_READING;
          end
        end
        PHASE_READING: begin
          // User let go, hand the bank back
          if (!read_activate) begin
            phase                 <= PHASE_IDLE;
            handoff.release_event <= 1'b1;
          end
        end
        default: begin
          phase <= PHASE_IDLE;
        end
      endcase
    end
  end

  // Saved counts of committed banks
  always_ff @(posedge write_clock) begin
    if (handoff.commit) begin
      bank_count[handoff.commit_bank] <= handoff.commit_count;
    end
  end

  // Selected bank, read offset and reported count
  always_ff @(posedge write_clock) begin
    offset <= offset_next;
    if (offer_now) begin
      sel_bank   <= take_bank;
      offset     <= '0;
      read_count <= (full != '0) ? bank_count[take_bank] : handoff.commit_count;
    end
    if ((phase == PHASE_READING) && !read_activate) begin
      handoff.release_bank <= sel_bank;
    end
  end

endmodule

`default_nettype wire

/* src/write_bank_control.sv */
// Write side of the ping-pong FIFO
// Bank claim through write_activate, word counting and memory writes,
// commit of filled banks and return of banks released by the reader
`timescale 1ns/1ps
`default_nettype none

module write_bank_control (
  input  wire logic                     write_clock,
  input  wire logic                     reset,
  output pingpong_pkg::bank_mask_t      write_ready,
  input  wire pingpong_pkg::bank_mask_t write_activate,
  input  wire logic                     write_strobe,
  input  wire pingpong_pkg::data_t      write_data,
  bank_handoff_if.writer                handoff,
  output logic                          mem_write_enable,
  output pingpong_pkg::ram_addr_t       mem_write_address,
  output pingpong_pkg::data_t           mem_write_data
);

  import pingpong_pkg::*;

  // Who owns each bank
  typedef enum logic [1:0] {
    OWNER_FREE,
    OWNER_FILLING,
    OWNER_READER
  } owner_t;

  owner_t owner [NUM_BANKS];

  logic   active;
  bank_t  active_bank;
  count_t fill_count;

  bank_t  selected_bank;
  logic   claim;
  logic   deactivate;
  logic   bank_full;

  // Bank picked by the one-hot activate
  assign selected_bank = bank_t'(write_activate[1]);

  // Free banks are ready; a release pulse makes its bank ready at once
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      write_ready[b] = (owner[b] == OWNER_FREE) ||
                       (handoff.release_event && (handoff.release_bank == bank_t'(b)));
    end
  end

  // New claim only from idle and only for a ready bank
  assign claim      = !active && (write_activate != '0) && write_ready[selected_bank];
  // Active bank dropped by the user
  assign deactivate = active && !write_activate[active_bank];
  assign bank_full  = (fill_count == count_t'(BANK_DEPTH));

  // Strobes go straight to memory, also on the claim cycle
  // Words beyond the bank depth are dropped
  assign mem_write_enable  = write_strobe && (claim || (active && !deactivate)) && !bank_full;
  assign mem_write_address = {selected_bank, offset_t'(fill_count)};
  assign mem_write_data    = write_data;

  // Ownership, fill count and commit pulse
  always_ff @(posedge write_clock) begin
    if (reset) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        owner[b] <= OWNER_FREE;
      end
      active         <= 1'b0;
      fill_count     <= '0;
      handoff.commit <= 1'b0;
    end else begin
      handoff.commit <= 1'b0;

      // Reader is done with a bank
      if (handoff.release_event) begin
        owner[handoff.release_bank] <= OWNER_FREE;
      end

      // Claim wins over a release of the same bank
      if (claim) begin
        owner[selected_bank] <= OWNER_FILLING;
        active               <= 1'b1;
      end

      if (mem_write_enable) begin
        fill_count <= fill_count + 1'b1;
      end

      // End of burst
      if (deactivate) begin
        active     <= 1'b0;
        fill_count <= '0;
        if (fill_count != '0) begin
          owner[active_bank] <= OWNER_READER;
          handoff.commit     <= 1'b1;
        end else begin
          // Nothing written, bank goes straight back
          owner[active_bank] <= OWNER_FREE;
        end
      end
    end
  end

  // Bank in use and the values sent along with commit
  always_ff @(posedge write_clock) begin
    if (claim) begin
      active_bank <= selected_bank;
    end
    if (deactivate) begin
      handoff.commit_bank  <= active_bank;
      handoff.commit_count <= fill_count;
    end
  end

endmodule

`default_nettype wire

/* verif/pingpong_fifo_assertions.sv */
// Protocol assertions for the ping-pong FIFO
// Bound to the top level, watches the write claim and the read hand-shake
`timescale 1ns/1ps
`default_nettype none

module pingpong_fifo_assertions (
  input wire logic                     write_clock,
  input wire logic                     reset,
  input wire pingpong_pkg::bank_mask_t write_ready,
  input wire pingpong_pkg::bank_mask_t write_activate,
  input wire logic                     read_ready,
  input wire logic                     read_activate
);

  // At most one bank claimed at a time
  activate_one_hot: assert property (
    @(posedge write_clock) disable iff (reset) $onehot0(write_activate)
  ) else $error("write_activate has more than one bit set");

  // A newly raised activate bit must point at a ready bank
  activate_only_ready: assert property (
    @(posedge write_clock) disable iff (reset)
      (write_activate & ~$past(write_activate) & ~write_ready) == '0
  ) else $error("write_activate raised for a bank that is not ready");

  // Offer withdrawn one cycle after the reader takes it
  ready_falls_after_activate: assert property (
    @(posedge write_clock) disable iff (reset)
      (read_ready && read_activate) |=> !read_ready
  ) else $error("read_ready still high one cycle after read_activate");

endmodule

bind pingpong_fifo pingpong_fifo_assertions i_pingpong_fifo_assertions (
  .write_clock    (write_clock),
  .reset          (reset),
  .write_ready    (write_ready),
  .write_activate (write_activate),
  .read_ready     (read_ready),
  .read_activate  (read_activate)
);

`default_nettype wire

/* verif/pingpong_fifo_tb.sv */
// Testbench for the ping-pong FIFO
// Writes random bursts into the banks, reads the blocks back
// and compares them with a queue model of the expected blocks
`timescale 1ns/1ps
`default_nettype none

module pingpong_fifo_tb;

  import pingpong_pkg::*;

  // Cycles allowed for any ready flag to rise
  localparam int TIMEOUT_CYCLES = 100;

  logic       write_clock = 1'b0;
  logic       reset;
  bank_mask_t write_ready;
  bank_mask_t write_activate;
  logic       write_strobe;
  data_t      write_data;
  logic       read_ready;
  logic       read_activate;
  logic       read_strobe;
  count_t     read_count;
  data_t      read_data;
  integer     seed;

  // Model of written bursts, in commit order
  data_t  model_words [$];
  int     model_lengths [$];
  // Blocks seen on the read side, not yet compared
  count_t observed_counts [$];
  data_t  observed_words [$];

  pingpong_fifo i_dut (
    .write_clock    (write_clock),
    .reset          (reset),
    .write_ready    (write_ready),
    .write_activate (write_activate),
    .write_strobe   (write_strobe),
    .write_data     (write_data),
    .read_ready     (read_ready),
    .read_activate  (read_activate),
    .read_strobe    (read_strobe),
    .read_count     (read_count),
    .read_data      (read_data)
  );

  // 20 ns clock
  always #10 write_clock = ~write_clock;

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_count(input count_t got, input count_t expected, input string what);
    if (got !== expected) begin
      $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_data(input data_t got, input data_t expected, input string what);
    if (got !== expected) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_mask(input bank_mask_t got, input bank_mask_t expected, input string what);
    if (got !== expected) begin
      $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, expected);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, expected);
      stop_on_failure();
    end
  endtask

  // Rising edge plus settle time, outputs stable and inputs safe to change
  task automatic step_cycle();
    @(posedge write_clock);
    #2;
  endtask

  function automatic int random_length();
    return 1 + int'($unsigned($random(seed)) % BANK_DEPTH);
  endfunction

  // Next block for the read side
  // Oldest burst first, empty bursts skipped, only BANK_DEPTH words kept
  function automatic count_t expected_block(output data_t words [BANK_DEPTH]);
    int    length;
    data_t word;
    length = 0;
    for (int i = 0; i < BANK_DEPTH; i++) begin
      words[i] = '0;
    end
    while ((length == 0) && (model_lengths.size() != 0)) begin
      length = model_lengths.pop_front();
    end
    for (int i = 0; i < length; i++) begin
      word = model_words.pop_front();
      if (i < BANK_DEPTH) begin
        words[i] = word;
      end
    end
    return (length > BANK_DEPTH) ? count_t'(BANK_DEPTH) : count_t'(length);
  endfunction

  task automatic wait_write_ready(input int bank);
    int cycles;
    cycles = 0;
    while (!write_ready[bank]) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("Timeout: write_ready of bank %0d stayed low for %0d cycles",
                 bank, TIMEOUT_CYCLES);
        stop_on_failure();
      end
      step_cycle();
      cycles++;
    end
  endtask

  task automatic wait_read_ready();
    int cycles;
    cycles = 0;
    while (!read_ready) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("Timeout: read_ready stayed low for %0d cycles", TIMEOUT_CYCLES);
        stop_on_failure();
      end
      step_cycle();
      cycles++;
    end
  endtask

  // Claim a bank, strobe in random words, then let go of it
  task automatic write_burst(input int bank, input int length);
    data_t word;
    wait_write_ready(bank);
    write_activate = bank_mask_t'(1 << bank);
    for (int i = 0; i < length; i++) begin
      word         = data_t'($random(seed));
      write_strobe = 1'b1;
      write_data   = word;
      model_words.push_back(word);
      step_cycle();
    end
    // Empty burst still needs the claim edge
    if (length == 0) begin
      step_cycle();
    end
    write_strobe   = 1'b0;
    write_activate = '0;
    model_lengths.push_back(length);
    step_cycle();
  endtask

  // Take the offered bank, step through its words, hand it back
  task automatic read_block();
    count_t count;
    int     words;
    data_t  block [BANK_DEPTH];
    wait_read_ready();
    count    = read_count;
    // Word 0 shows up without a strobe
    block[0] = read_data;
    words    = (int'(count) > BANK_DEPTH) ? BANK_DEPTH : int'(count);
    read_activate = 1'b1;
    step_cycle();
    for (int i = 1; i < words; i++) begin
      read_strobe = 1'b1;
      step_cycle();
      block[i] = read_data;
    end
    read_strobe   = 1'b0;
    read_activate = 1'b0;
    step_cycle();
    // Whole block queued in one time step
    observed_counts.push_back(count);
    for (int i = 0; i < words; i++) begin
      observed_words.push_back(block[i]);
    end
  endtask

  // Compares each captured block with the model
  always @(posedge write_clock) begin : compare_blocks
    count_t got_count;
    count_t want_count;
    data_t  want_words [BANK_DEPTH];
    while (observed_counts.size() != 0) begin
      got_count  = observed_counts.pop_front();
      want_count = expected_block(want_words);
      check_count(got_count, want_count, "read_count");
      for (int i = 0; i < int'(want_count); i++) begin
        check_data(observed_words.pop_front(), want_words[i],
                   $sformatf("read_data word %0d", i));
      end
    end
  end

  initial begin
    seed           = 32'h729d;
    reset          = 1'b1;
    write_activate = '0;
    write_strobe   = 1'b0;
    write_data     = '0;
    read_activate  = 1'b0;
    read_strobe    = 1'b0;
    repeat (4) step_cycle();
    reset = 1'b0;
    step_cycle();

    // Idle state after reset
    check_mask(write_ready, 2'b11, "write_ready after reset");
    check_flag(read_ready, 1'b0, "read_ready after reset");

    // Single round trip through bank 0
    write_burst(0, random_length());
    read_block();
    check_mask(write_ready, 2'b11, "write_ready after release of bank 0");

    // Bank 0 then bank 1, read back in commit order
    write_burst(0, random_length());
    write_burst(1, random_length());
    read_block();
    read_block();

    // Both banks committed and unread, bank 1 first
    write_burst(1, random_length());
    write_burst(0, random_length());
    repeat (40) begin
      check_mask(write_ready, 2'b00, "write_ready with both banks committed");
      step_cycle();
    end
    read_block();
    check_mask(write_ready, 2'b10, "write_ready after release of bank 1");
    read_block();
    check_mask(write_ready, 2'b11, "write_ready after release of bank 0");

    // Claim and drop bank 0 without strobes
    write_burst(0, 0);
    check_mask(write_ready, 2'b11, "write_ready after empty activation");
    repeat (10) begin
      check_flag(read_ready, 1'b0, "read_ready after empty activation");
      step_cycle();
    end

    // 20 strobes into a 16 word bank
    write_burst(1, 20);
    read_block();
    check_mask(write_ready, 2'b11, "write_ready after saturated block");

    // Give the comparing process time to drain
    repeat (2) step_cycle();
    if ((observed_counts.size() != 0) || (model_lengths.size() != 0)) begin
      $display("Blocks left unchecked: %0d read, %0d written",
               observed_counts.size(), model_lengths.size());
      stop_on_failure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire
